// ==== filelist.f ====
+incdir+rtl
+incdir+verif
rtl/issue_pkg.sv
rtl/issue_bank_ram.sv
rtl/issue_queue.sv
rtl/issue_select.sv
rtl/issue_stage.sv
verif/issue_tb.sv

// ==== rtl/issue_bank_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module issue_bank_ram #(
    parameter int DEPTH = `ISSUE_BANK_DEPTH,
    parameter int WIDTH = `ISSUE_ENTRY_W
) (
    input  logic                                 clk,
    input  logic                                 wen,
    input  logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] waddr,
    input  logic [WIDTH-1:0]                     wdata,
    input  logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] raddr,
    output logic [WIDTH-1:0]                     rdata
);

    // storage only, validity is tracked by the pointers outside
    logic [WIDTH-1:0] mem [DEPTH];

    // write lands at the rising edge
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // asynchronous read, the head entry is visible in the same cycle
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

// ==== rtl/issue_pkg.sv ====
`default_nettype none

`include "issue_settings.svh"

package issue_pkg;

    // data operand or pc
    typedef logic [`WORD_W-1:0] word_t;

    // architectural register number
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // pointer into one bank of the queue
    typedef logic [`ISSUE_IDX_W-1:0] qidx_t;

    // one decoded instruction as stored in a bank
    // field positions come from the ENT_* macros
    typedef logic [`ISSUE_ENTRY_W-1:0] entry_t;

endpackage

`default_nettype wire

// ==== rtl/issue_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module issue_queue (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              flush,
    input  logic              stall,
    input  logic              in0_valid,
    input  logic              in1_valid,
    input  issue_pkg::entry_t in0_entry,
    input  issue_pkg::entry_t in1_entry,
    input  logic              take0,
    input  logic              take1,
    output logic              cand0_valid,
    output logic              cand1_valid,
    output issue_pkg::entry_t cand0_entry,
    output issue_pkg::entry_t cand1_entry,
    output logic              full
);

    // per bank pointers
    issue_pkg::qidx_t head_even;
    issue_pkg::qidx_t head_odd;
    issue_pkg::qidx_t tail_even;
    issue_pkg::qidx_t tail_odd;

    // bank ports
    issue_pkg::entry_t rdata_even;
    issue_pkg::entry_t rdata_odd;
    issue_pkg::entry_t wdata_even;
    issue_pkg::entry_t wdata_odd;
    logic              wen_even;
    logic              wen_odd;

    // ordering between the banks
    logic wr_odd_first;
    logic rd_odd_first;
    logic empty_even;
    logic empty_odd;

    logic accept;
    logic pop_even;
    logic pop_odd;

    // wrap comes for free with a power of two depth
    function automatic issue_pkg::qidx_t next_idx(input issue_pkg::qidx_t idx);
        return idx + issue_pkg::qidx_t'(1);
    endfunction

    issue_bank_ram #(
        .DEPTH(`ISSUE_BANK_DEPTH),
        .WIDTH(`ISSUE_ENTRY_W)
    ) bank_even_i (
        .clk  (clk),
        .wen  (wen_even),
        .waddr(tail_even),
        .wdata(wdata_even),
        .raddr(head_even),
        .rdata(rdata_even)
    );

    issue_bank_ram #(
        .DEPTH(`ISSUE_BANK_DEPTH),
        .WIDTH(`ISSUE_ENTRY_W)
    ) bank_odd_i (
        .clk  (clk),
        .wen  (wen_odd),
        .waddr(tail_odd),
        .wdata(wdata_odd),
        .raddr(head_odd),
        .rdata(rdata_odd)
    );

    // odd bank takes the next write when the tails match
    assign wr_odd_first = (tail_odd == tail_even);
    // odd bank holds the oldest entry when the heads match
    assign rd_odd_first = (head_odd == head_even);

    assign empty_even = (head_even == tail_even);
    assign empty_odd  = (head_odd == tail_odd);

    // one slot per bank stays free so head==tail means empty
    assign full = (next_idx(tail_even) == head_even) || (next_idx(tail_odd) == head_odd);

    // nothing enters while held, full or flushing
    assign accept = ~stall & ~full & ~flush;

    // in0 goes to the bank next in order and in1 to the other one
    always_comb begin
        wdata_odd  = wr_odd_first ? in0_entry : in1_entry;
        wdata_even = wr_odd_first ? in1_entry : in0_entry;
        wen_odd    = accept & (wr_odd_first ? in0_valid : in1_valid);
        wen_even   = accept & (wr_odd_first ? in1_valid : in0_valid);
    end

    // oldest first and zeroed when its bank is empty
    always_comb begin
        cand0_valid = rd_odd_first ? ~empty_odd : ~empty_even;
        cand1_valid = rd_odd_first ? ~empty_even : ~empty_odd;
        cand0_entry = rd_odd_first ? rdata_odd : rdata_even;
        cand1_entry = rd_odd_first ? rdata_even : rdata_odd;
        if (!cand0_valid) begin
            cand0_entry = '0;
        end
        if (!cand1_valid) begin
            cand1_entry = '0;
        end
    end

    // one head step per taken slot
    assign pop_odd  = rd_odd_first ? take0 : take1;
    assign pop_even = rd_odd_first ? take1 : take0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tail_even <= '0;
            tail_odd  <= '0;
        end else if (flush) begin
            tail_even <= '0;
            tail_odd  <= '0;
        end else begin
            if (wen_even) begin
                tail_even <= next_idx(tail_even);
            end
            if (wen_odd) begin
                tail_odd <= next_idx(tail_odd);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_even <= '0;
            head_odd  <= '0;
        end else if (flush) begin
            head_even <= '0;
            head_odd  <= '0;
        end else if (!stall) begin
            if (pop_even) begin
                head_even <= next_idx(head_even);
            end
            if (pop_odd) begin
                head_odd <= next_idx(head_odd);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/issue_select.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module issue_select (
    input  logic                 cand0_valid,
    input  logic                 cand1_valid,
    input  issue_pkg::entry_t    cand0_entry,
    input  issue_pkg::entry_t    cand1_entry,
    input  issue_pkg::word_t     rf0_a,
    input  issue_pkg::word_t     rf0_b,
    input  issue_pkg::word_t     rf1_a,
    input  issue_pkg::word_t     rf1_b,
    input  logic                 rdy0_a,
    input  logic                 rdy0_b,
    input  logic                 rdy1_a,
    input  logic                 rdy1_b,
    input  logic                 hit0_a,
    input  logic                 hit0_b,
    input  logic                 hit1_a,
    input  logic                 hit1_b,
    input  issue_pkg::word_t     byp0_a,
    input  issue_pkg::word_t     byp0_b,
    input  issue_pkg::word_t     byp1_a,
    input  issue_pkg::word_t     byp1_b,
    output logic                 take0,
    output logic                 take1,
    output issue_pkg::reg_addr_t rf_addr0_a,
    output issue_pkg::reg_addr_t rf_addr0_b,
    output issue_pkg::reg_addr_t rf_addr1_a,
    output issue_pkg::reg_addr_t rf_addr1_b,
    output logic                 iss0_valid,
    output logic                 iss1_valid,
    output logic                 iss1_is_slot,
    output issue_pkg::word_t     iss0_pc,
    output issue_pkg::word_t     iss1_pc,
    output issue_pkg::reg_addr_t iss0_rdst,
    output issue_pkg::reg_addr_t iss1_rdst,
    output logic                 iss0_regwrite,
    output logic                 iss1_regwrite,
    output logic                 iss0_ctrl,
    output logic                 iss1_ctrl,
    output issue_pkg::word_t     iss0_op_a,
    output issue_pkg::word_t     iss0_op_b,
    output issue_pkg::word_t     iss1_op_a,
    output issue_pkg::word_t     iss1_op_b
);

    // field views of the older (c0) and younger (c1) candidate
    issue_pkg::word_t     c0_pc;
    issue_pkg::word_t     c1_pc;
    issue_pkg::reg_addr_t c0_rdst;
    issue_pkg::reg_addr_t c1_rdst;
    issue_pkg::reg_addr_t c1_ra1;
    issue_pkg::reg_addr_t c1_ra2;
    logic c0_regwrite;
    logic c1_regwrite;
    logic c0_ctrl;
    logic c1_ctrl;
    logic c0_muldiv;
    logic c1_muldiv;
    logic c0_serial;
    logic c1_serial;

    logic c0_ready;
    logic c1_ready;
    logic raw_hazard;
    logic pair_block;

    assign c0_pc       = cand0_entry[`ENT_PC +: `WORD_W];
    assign c1_pc       = cand1_entry[`ENT_PC +: `WORD_W];
    assign c0_rdst     = cand0_entry[`ENT_RDST +: `REG_ADDR_W];
    assign c1_rdst     = cand1_entry[`ENT_RDST +: `REG_ADDR_W];
    assign c1_ra1      = cand1_entry[`ENT_RA1 +: `REG_ADDR_W];
    assign c1_ra2      = cand1_entry[`ENT_RA2 +: `REG_ADDR_W];
    assign c0_regwrite = cand0_entry[`ENT_REGWRITE];
    assign c1_regwrite = cand1_entry[`ENT_REGWRITE];
    assign c0_ctrl     = cand0_entry[`ENT_CTRL];
    assign c1_ctrl     = cand1_entry[`ENT_CTRL];
    assign c0_muldiv   = cand0_entry[`ENT_MULDIV];
    assign c1_muldiv   = cand1_entry[`ENT_MULDIV];
    assign c0_serial   = cand0_entry[`ENT_SERIAL];
    assign c1_serial   = cand1_entry[`ENT_SERIAL];

    // read addresses go out straight from the candidates
    assign rf_addr0_a = cand0_entry[`ENT_RA1 +: `REG_ADDR_W];
    assign rf_addr0_b = cand0_entry[`ENT_RA2 +: `REG_ADDR_W];
    assign rf_addr1_a = c1_ra1;
    assign rf_addr1_b = c1_ra2;

    assign c0_ready = cand0_valid & rdy0_a & rdy0_b;
    assign c1_ready = cand1_valid & rdy1_a & rdy1_b;

    // a branch never leaves without its delay slot
    assign take0 = c0_ready & (~c0_ctrl | c1_ready);

    // slot reading the branch's link register still pairs
    assign raw_hazard = c0_regwrite & ~c0_ctrl & ((c0_rdst == c1_ra1) | (c0_rdst == c1_ra2));

    // one mul/div unit, no transfer in slot 1, serial goes alone
    assign pair_block = raw_hazard | (c0_muldiv & c1_muldiv) | c1_ctrl | c0_serial | c1_serial;

    assign take1 = take0 & c1_ready & ~pair_block;

    assign iss0_valid   = take0;
    assign iss1_valid   = take1;
    assign iss1_is_slot = take1 & c0_ctrl;

    // issued fields, zero in an empty slot
    assign iss0_pc       = take0 ? c0_pc : '0;
    assign iss1_pc       = take1 ? c1_pc : '0;
    assign iss0_rdst     = take0 ? c0_rdst : '0;
    assign iss1_rdst     = take1 ? c1_rdst : '0;
    assign iss0_regwrite = take0 & c0_regwrite;
    assign iss1_regwrite = take1 & c1_regwrite;
    assign iss0_ctrl     = take0 & c0_ctrl;
    assign iss1_ctrl     = take1 & c1_ctrl;

    // bypass data wins over the register file on a hit
    assign iss0_op_a = take0 ? (hit0_a ? byp0_a : rf0_a) : '0;
    assign iss0_op_b = take0 ? (hit0_b ? byp0_b : rf0_b) : '0;
    assign iss1_op_a = take1 ? (hit1_a ? byp1_a : rf1_a) : '0;
    assign iss1_op_b = take1 ? (hit1_b ? byp1_b : rf1_b) : '0;

endmodule

`default_nettype wire

// ==== rtl/issue_settings.svh ====
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// queue geometry, counted per bank
`define ISSUE_BANK_DEPTH 16
`define ISSUE_IDX_W 4

// datapath widths
`define WORD_W 32
`define REG_ADDR_W 5

// stored entry: pc on top, then rdst, ra1, ra2, flags at the bottom
`define ISSUE_ENTRY_W 51
`define ENT_PC 19
`define ENT_RDST 14
`define ENT_RA1 9
`define ENT_RA2 4
// single-bit flags
`define ENT_REGWRITE 3
`define ENT_CTRL 2
`define ENT_MULDIV 1
`define ENT_SERIAL 0

`endif

// ==== rtl/issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 flush,
    input  logic                 stall,
    // decoded pair from upstream, in0 is older
    input  logic                 in0_valid,
    input  logic                 in1_valid,
    input  issue_pkg::entry_t    in0_entry,
    input  issue_pkg::entry_t    in1_entry,
    // operand sources, slot 0 older
    input  issue_pkg::word_t     rf0_a,
    input  issue_pkg::word_t     rf0_b,
    input  issue_pkg::word_t     rf1_a,
    input  issue_pkg::word_t     rf1_b,
    input  logic                 rdy0_a,
    input  logic                 rdy0_b,
    input  logic                 rdy1_a,
    input  logic                 rdy1_b,
    input  logic                 hit0_a,
    input  logic                 hit0_b,
    input  logic                 hit1_a,
    input  logic                 hit1_b,
    input  issue_pkg::word_t     byp0_a,
    input  issue_pkg::word_t     byp0_b,
    input  issue_pkg::word_t     byp1_a,
    input  issue_pkg::word_t     byp1_b,
    output issue_pkg::reg_addr_t rf_addr0_a,
    output issue_pkg::reg_addr_t rf_addr0_b,
    output issue_pkg::reg_addr_t rf_addr1_a,
    output issue_pkg::reg_addr_t rf_addr1_b,
    // issued pair
    output logic                 iss0_valid,
    output logic                 iss1_valid,
    output logic                 iss1_is_slot,
    output issue_pkg::word_t     iss0_pc,
    output issue_pkg::word_t     iss1_pc,
    output issue_pkg::reg_addr_t iss0_rdst,
    output issue_pkg::reg_addr_t iss1_rdst,
    output logic                 iss0_regwrite,
    output logic                 iss1_regwrite,
    output logic                 iss0_ctrl,
    output logic                 iss1_ctrl,
    output issue_pkg::word_t     iss0_op_a,
    output issue_pkg::word_t     iss0_op_b,
    output issue_pkg::word_t     iss1_op_a,
    output issue_pkg::word_t     iss1_op_b,
    output logic                 full
);

    // queue heads towards the selector
    logic              cand0_valid;
    logic              cand1_valid;
    issue_pkg::entry_t cand0_entry;
    issue_pkg::entry_t cand1_entry;
    // pop requests back to the queue
    logic              take0;
    logic              take1;

    issue_queue queue_i (
        .clk, .arst_n, .flush, .stall,
        .in0_valid, .in1_valid, .in0_entry, .in1_entry,
        .take0, .take1,
        .cand0_valid, .cand1_valid, .cand0_entry, .cand1_entry,
        .full
    );

    issue_select select_i (
        .cand0_valid, .cand1_valid, .cand0_entry, .cand1_entry,
        .rf0_a, .rf0_b, .rf1_a, .rf1_b,
        .rdy0_a, .rdy0_b, .rdy1_a, .rdy1_b,
        .hit0_a, .hit0_b, .hit1_a, .hit1_b,
        .byp0_a, .byp0_b, .byp1_a, .byp1_b,
        .take0, .take1,
        .rf_addr0_a, .rf_addr0_b, .rf_addr1_a, .rf_addr1_b,
        .iss0_valid, .iss1_valid, .iss1_is_slot,
        .iss0_pc, .iss1_pc, .iss0_rdst, .iss1_rdst,
        .iss0_regwrite, .iss1_regwrite, .iss0_ctrl, .iss1_ctrl,
        .iss0_op_a, .iss0_op_b, .iss1_op_a, .iss1_op_b
    );

endmodule

`default_nettype wire

// ==== verif/issue_tb_tasks.svh ====
`ifndef ISSUE_TB_TASKS_SVH
`define ISSUE_TB_TASKS_SVH

task automatic check_word(input string name, input issue_pkg::word_t got,
                          input issue_pkg::word_t exp);
    if (got !== exp) begin
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        err_count++;
    end
endtask

task automatic check_reg(input string name, input issue_pkg::reg_addr_t got,
                         input issue_pkg::reg_addr_t exp);
    if (got !== exp) begin
        $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
        err_count++;
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
        err_count++;
    end
endtask

// starts on a falling edge and returns on the falling edge after the write
task automatic push(input issue_pkg::entry_t e0, input issue_pkg::entry_t e1, input logic v1);
    in0_entry = e0;
    in1_entry = e1;
    in0_valid = 1'b1;
    in1_valid = v1;
    @(posedge clk);
    @(negedge clk);
    in0_valid = 1'b0;
    in1_valid = 1'b0;
endtask

task automatic wait_issue(input int limit, input string what);
    int n;
    n = 0;
    do begin
        @(negedge clk);
        n++;
    end while (!iss0_valid && n < limit);
    if (!iss0_valid) begin
        $display("timeout: %s never issued after %0d cycles", what, limit);
        timeout_count++;
    end
endtask

task automatic check_empty();
    check_bit("iss0_valid", iss0_valid, 1'b0);
    check_bit("iss1_valid", iss1_valid, 1'b0);
endtask

task automatic test_reset_and_pair();
    issue_pkg::word_t pc0;
    issue_pkg::word_t pc1;
    issue_pkg::reg_addr_t d0;
    issue_pkg::reg_addr_t d1;
    issue_pkg::reg_addr_t a0;
    issue_pkg::reg_addr_t b0;
    issue_pkg::reg_addr_t a1;
    issue_pkg::reg_addr_t b1;
    pc0 = rand_pc();
    pc1 = pc0 + 4;
    d0 = hi_reg();
    d1 = hi_reg();
    a0 = lo_reg();
    b0 = lo_reg();
    a1 = lo_reg();
    b1 = lo_reg();
    check_empty();
    check_bit("iss1_is_slot", iss1_is_slot, 1'b0);
    check_bit("full", full, 1'b0);
    push(make_entry(pc0, d0, a0, b0, 1, 0, 0, 0),
         make_entry(pc1, d1, a1, b1, 0, 0, 0, 0), 1);
    check_bit("iss0_valid", iss0_valid, 1'b1);
    check_bit("iss1_valid", iss1_valid, 1'b1);
    check_bit("iss1_is_slot", iss1_is_slot, 1'b0);
    check_word("iss0_pc", iss0_pc, pc0);
    check_word("iss1_pc", iss1_pc, pc1);
    check_reg("iss0_rdst", iss0_rdst, d0);
    check_reg("iss1_rdst", iss1_rdst, d1);
    check_bit("iss0_regwrite", iss0_regwrite, 1'b1);
    check_bit("iss1_regwrite", iss1_regwrite, 1'b0);
    check_word("iss0_op_a", iss0_op_a, rf_value(a0));
    check_word("iss0_op_b", iss0_op_b, rf_value(b0));
    check_word("iss1_op_a", iss1_op_a, rf_value(a1));
    check_word("iss1_op_b", iss1_op_b, rf_value(b1));
    @(negedge clk);
    check_empty();
endtask

task automatic test_raw();
    issue_pkg::word_t pc0;
    issue_pkg::reg_addr_t d;
    pc0 = rand_pc();
    d = hi_reg();
    // younger reads the older's destination in its first operand
    push(make_entry(pc0, d, lo_reg(), lo_reg(), 1, 0, 0, 0),
         make_entry(pc0 + 4, hi_reg(), d, lo_reg(), 1, 0, 0, 0), 1);
    check_bit("iss0_valid", iss0_valid, 1'b1);
    check_word("iss0_pc", iss0_pc, pc0);
    check_bit("iss1_valid", iss1_valid, 1'b0);
    @(negedge clk);
    check_bit("iss0_valid", iss0_valid, 1'b1);
    check_word("iss0_pc", iss0_pc, pc0 + 4);
    check_word("iss0_op_a", iss0_op_a, rf_value(d));
    check_bit("iss1_valid", iss1_valid, 1'b0);
    @(negedge clk);
    check_empty();
endtask

// pair that must split into the older and then the younger alone
task automatic expect_split(input issue_pkg::entry_t e0, input issue_pkg::entry_t e1,
                            input issue_pkg::word_t pc0, input issue_pkg::word_t pc1);
    push(e0, e1, 1);
    check_bit("iss0_valid", iss0_valid, 1'b1);
    check_word("iss0_pc", iss0_pc, pc0);
    check_bit("iss1_valid", iss1_valid, 1'b0);
    @(negedge clk);
    check_bit("iss0_valid", iss0_valid, 1'b1);
    check_word("iss0_pc", iss0_pc, pc1);
    check_bit("iss1_valid", iss1_valid, 1'b0);
    @(negedge clk);
    check_empty();
endtask

task automatic test_pair_rules();
    issue_pkg::word_t pc;
    pc = rand_pc();
    // both on the mul/div unit
    expect_split(make_entry(pc, hi_reg(), lo_reg(), lo_reg(), 1, 0, 1, 0),
                 make_entry(pc + 4, hi_reg(), lo_reg(), lo_reg(), 1, 0, 1, 0), pc, pc + 4);
    pc = rand_pc();
    // serial older
    expect_split(make_entry(pc, hi_reg(), lo_reg(), lo_reg(), 1, 0, 0, 1),
                 make_entry(pc + 4, hi_reg(), lo_reg(), lo_reg(), 1, 0, 0, 0), pc, pc + 4);
    pc = rand_pc();
    // jump in slot 1 waits a cycle and then leaves with its delay slot
    push(make_entry(pc, hi_reg(), lo_reg(), lo_reg(), 1, 0, 0, 0),
         make_entry(pc + 4, 5'd0, lo_reg(), lo_reg(), 0, 1, 0, 0), 1);
    check_word("iss0_pc", iss0_pc, pc);
    check_bit("iss1_valid", iss1_valid, 1'b0);
    check_bit("iss1_ctrl", iss1_ctrl, 1'b0);
    push(make_entry(pc + 8, hi_reg(), lo_reg(), lo_reg(), 1, 0, 0, 0), '0, 0);
    check_word("iss0_pc", iss0_pc, pc + 4);
    check_bit("iss0_ctrl", iss0_ctrl, 1'b1);
    check_bit("iss0_regwrite", iss0_regwrite, 1'b0);
    check_word("iss1_pc", iss1_pc, pc + 8);
    check_bit("iss1_is_slot", iss1_is_slot, 1'b1);
    @(negedge clk);
    check_empty();
endtask

task automatic test_branch_slot();
    issue_pkg::word_t pc;
    pc = rand_pc();
    // link register written by the branch and read by its slot
    push(make_entry(pc, 5'd31, lo_reg(), lo_reg(), 1, 1, 0, 0),
         make_entry(pc + 4, hi_reg(), 5'd31, lo_reg(), 1, 0, 0, 0), 1);
    check_bit("iss0_valid", iss0_valid, 1'b1);
    check_bit("iss0_ctrl", iss0_ctrl, 1'b1);
    check_bit("iss1_valid", iss1_valid, 1'b1);
    check_bit("iss1_is_slot", iss1_is_slot, 1'b1);
    check_word("iss1_op_a", iss1_op_a, rf_value(5'd31));
    @(negedge clk);
    check_empty();
    pc = rand_pc();
    rdy1_a = 1'b0;
    push(make_entry(pc, 5'd0, lo_reg(), lo_reg(), 0, 1, 0, 0),
         make_entry(pc + 4, hi_reg(), lo_reg(), lo_reg(), 1, 0, 0, 0), 1);
    for (int i = 0; i < 3; i++) begin
        check_empty();
        @(negedge clk);
    end
    // stall keeps the pair visible at the sample point
    stall = 1'b1;
    rdy1_a = 1'b1;
    wait_issue(8, "branch with slot");
    check_word("iss0_pc", iss0_pc, pc);
    check_bit("iss1_valid", iss1_valid, 1'b1);
    check_word("iss1_pc", iss1_pc, pc + 4);
    check_bit("iss1_is_slot", iss1_is_slot, 1'b1);
    stall = 1'b0;
    @(negedge clk);
    check_empty();
endtask

task automatic test_bypass_stall();
    issue_pkg::word_t pc;
    issue_pkg::word_t v;
    issue_pkg::reg_addr_t b;
    pc = rand_pc();
    v = rand_bits(32);
    b = lo_reg();
    hit0_a = 1'b1;
    byp0_a = v;
    push(make_entry(pc, hi_reg(), lo_reg(), b, 1, 0, 0, 0), '0, 0);
    check_word("iss0_op_a", iss0_op_a, v);
    check_word("iss0_op_b", iss0_op_b, rf_value(b));
    hit0_a = 1'b0;
    @(negedge clk);
    check_empty();
    pc = rand_pc();
    rdy0_b = 1'b0;
    push(make_entry(pc, hi_reg(), lo_reg(), lo_reg(), 1, 0, 0, 0), '0, 0);
    check_bit("iss0_valid", iss0_valid, 1'b0);
    stall = 1'b1;
    repeat (2) begin
        @(negedge clk);
        check_bit("iss0_valid", iss0_valid, 1'b0);
    end
    rdy0_b = 1'b1;
    wait_issue(8, "operand wait");
    check_word("iss0_pc", iss0_pc, pc);
    // not popped while stalled
    @(negedge clk);
    check_bit("iss0_valid", iss0_valid, 1'b1);
    check_word("iss0_pc", iss0_pc, pc);
    stall = 1'b0;
    @(negedge clk);
    check_empty();
endtask

task automatic test_full_flush();
    // the bank written first reaches 15 entries after 29 single writes
    rdy0_a = 1'b0;
    for (int i = 0; i < 2 * (`ISSUE_BANK_DEPTH - 1) - 1; i++) begin
        check_bit("full", full, 1'b0);
        push(make_entry(rand_pc(), hi_reg(), lo_reg(), lo_reg(), 1, 0, 0, 0), '0, 0);
    end
    check_bit("full", full, 1'b1);
    check_empty();
    flush = 1'b1;
    rdy0_a = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    check_bit("full", full, 1'b0);
    check_empty();
endtask

`endif

// ==== verif/issue_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module issue_tb;

    logic clk;
    logic arst_n;
    logic flush;
    logic stall;
    logic in0_valid;
    logic in1_valid;
    issue_pkg::entry_t in0_entry;
    issue_pkg::entry_t in1_entry;

    // rf data follows the read addresses
    issue_pkg::word_t rf0_a;
    issue_pkg::word_t rf0_b;
    issue_pkg::word_t rf1_a;
    issue_pkg::word_t rf1_b;
    logic rdy0_a;
    logic rdy0_b;
    logic rdy1_a;
    logic rdy1_b;
    logic hit0_a;
    logic hit0_b;
    logic hit1_a;
    logic hit1_b;
    issue_pkg::word_t byp0_a;
    issue_pkg::word_t byp0_b;
    issue_pkg::word_t byp1_a;
    issue_pkg::word_t byp1_b;
    issue_pkg::reg_addr_t rf_addr0_a;
    issue_pkg::reg_addr_t rf_addr0_b;
    issue_pkg::reg_addr_t rf_addr1_a;
    issue_pkg::reg_addr_t rf_addr1_b;

    // issued pair
    logic iss0_valid;
    logic iss1_valid;
    logic iss1_is_slot;
    issue_pkg::word_t iss0_pc;
    issue_pkg::word_t iss1_pc;
    issue_pkg::reg_addr_t iss0_rdst;
    issue_pkg::reg_addr_t iss1_rdst;
    logic iss0_regwrite;
    logic iss1_regwrite;
    logic iss0_ctrl;
    logic iss1_ctrl;
    issue_pkg::word_t iss0_op_a;
    issue_pkg::word_t iss0_op_b;
    issue_pkg::word_t iss1_op_a;
    issue_pkg::word_t iss1_op_b;
    logic full;

    int err_count;
    int timeout_count;
    logic [15:0] lfsr_state;

    // 4 ns period
    initial clk = 1'b0;
    always #2 clk = ~clk;

    // register file contents as a fixed pattern of the register number
    function automatic issue_pkg::word_t rf_value(input issue_pkg::reg_addr_t r);
        return 32'h5A00_0000 | (issue_pkg::word_t'(r) * 32'h0001_0203);
    endfunction

    assign rf0_a = rf_value(rf_addr0_a);
    assign rf0_b = rf_value(rf_addr0_b);
    assign rf1_a = rf_value(rf_addr1_a);
    assign rf1_b = rf_value(rf_addr1_b);

    // 16-bit fibonacci lfsr with taps 16 14 13 11 stepped once per bit
    function automatic issue_pkg::word_t rand_bits(input int n);
        issue_pkg::word_t r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // destinations in r16..r31 and sources in r0..r15 keep pairs free of raw
    function automatic issue_pkg::reg_addr_t hi_reg();
        return issue_pkg::reg_addr_t'(rand_bits(4)) | 5'h10;
    endfunction

    function automatic issue_pkg::reg_addr_t lo_reg();
        return issue_pkg::reg_addr_t'(rand_bits(4));
    endfunction

    function automatic issue_pkg::word_t rand_pc();
        issue_pkg::word_t r;
        r = rand_bits(30);
        return {r[29:0], 2'b00};
    endfunction

    function automatic issue_pkg::entry_t make_entry(
        input issue_pkg::word_t pc,
        input issue_pkg::reg_addr_t rdst,
        input issue_pkg::reg_addr_t ra1,
        input issue_pkg::reg_addr_t ra2,
        input logic regwrite,
        input logic ctrl,
        input logic muldiv,
        input logic serial
    );
        issue_pkg::entry_t e;
        e = '0;
        e[`ENT_PC +: `WORD_W] = pc;
        e[`ENT_RDST +: `REG_ADDR_W] = rdst;
        e[`ENT_RA1 +: `REG_ADDR_W] = ra1;
        e[`ENT_RA2 +: `REG_ADDR_W] = ra2;
        e[`ENT_REGWRITE] = regwrite;
        e[`ENT_CTRL] = ctrl;
        e[`ENT_MULDIV] = muldiv;
        e[`ENT_SERIAL] = serial;
        return e;
    endfunction

    issue_stage dut_i (.*);

    `include "issue_tb_tasks.svh"

    initial begin
        err_count = 0;
        timeout_count = 0;
        lfsr_state = 16'd53;
        arst_n = 1'b0;
        flush = 1'b0;
        stall = 1'b0;
        in0_valid = 1'b0;
        in1_valid = 1'b0;
        in0_entry = '0;
        in1_entry = '0;
        {rdy0_a, rdy0_b, rdy1_a, rdy1_b} = 4'b1111;
        {hit0_a, hit0_b, hit1_a, hit1_b} = 4'b0000;
        {byp0_a, byp0_b, byp1_a, byp1_b} = '0;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;

        test_reset_and_pair();
        test_raw();
        test_pair_rules();
        test_branch_slot();
        test_bypass_stall();
        test_full_flush();

        $display("done: %0d mismatches, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
